// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

    // address and word widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // cache geometry
    localparam int NUM_LINES      = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int INDEX_W        = $clog2(NUM_LINES);
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);

    // byte lane bits below the word offset
    localparam int BYTE_OFF_W = 2;

    // field positions inside a byte address
    localparam int OFFSET_LSB = BYTE_OFF_W;
    localparam int INDEX_LSB  = OFFSET_LSB + OFFSET_W;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_W;
    localparam int TAG_W      = ADDR_W - TAG_LSB;

    // controller states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        REFILL = 3'd2,
        UPDATE = 3'd3,
        FLUSH  = 3'd4
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic cpu_req_valid,
    input  logic flush,
    input  logic hit,
    input  logic refill_done,
    output logic lookup_en,
    output logic refill_start,
    output logic tag_write,
    output logic flush_all,
    output logic cpu_req_ready
);
    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        fetch_pending;

    // a valid that is being answered this cycle is not a new fetch
    assign fetch_pending = cpu_req_valid && !cpu_req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (fetch_pending)
                begin
                    state_next = LOOKUP;
                end
                else if (flush)
                begin
                    state_next = FLUSH;
                end
            end
            LOOKUP:
            begin
                if (hit)
                begin
                    state_next = IDLE;
                end
                else
                begin
                    state_next = REFILL;
                end
            end
            REFILL:
            begin
                if (refill_done)
                begin
                    state_next = UPDATE;
                end
            end
            // tag lands at this edge so the next lookup hits
            UPDATE:
            begin
                state_next = LOOKUP;
            end
            FLUSH:
            begin
                state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    assign lookup_en    = (state == IDLE) && fetch_pending;
    assign refill_start = (state == LOOKUP) && !hit;
    assign tag_write    = (state == UPDATE);
    assign flush_all    = (state == FLUSH);

    // one-cycle response lined up with the registered data word
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cpu_req_ready <= 1'b0;
        end
        else
        begin
            cpu_req_ready <= (state == LOOKUP) && hit;
        end
    end

endmodule

`default_nettype wire

// File: icache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         lookup_en,
    input  logic [icache_pkg::ADDR_W-1:0] cpu_req_addr,
    input  logic                         tag_write,
    input  logic                         flush_all,
    output logic                         hit
);
    import icache_pkg::*;

    logic [NUM_LINES-1:0] valid;
    logic [TAG_W-1:0]     tags [NUM_LINES];
    logic [INDEX_W-1:0]   idx_q;
    logic [TAG_W-1:0]     tag_q;

    // capture the request fields for the compare cycle
    always_ff @(posedge clk)
    begin
        if (lookup_en)
        begin
            idx_q <= cpu_req_addr[INDEX_LSB +: INDEX_W];
            tag_q <= cpu_req_addr[TAG_LSB +: TAG_W];
        end
    end

    always_ff @(posedge clk)
    begin
        if (tag_write)
        begin
            tags[idx_q] <= tag_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush_all)
        begin
            valid <= '0;
        end
        else if (tag_write)
        begin
            valid[idx_q] <= 1'b1;
        end
    end

    assign hit = valid[idx_q] && (tags[idx_q] == tag_q);

endmodule

`default_nettype wire

// File: icache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data_array (
    input  logic                           clk,
    input  logic [icache_pkg::ADDR_W-1:0]   cpu_req_addr,
    input  logic                           data_we,
    input  logic [icache_pkg::OFFSET_W-1:0] wr_offset,
    input  logic [icache_pkg::DATA_W-1:0]   wr_data,
    output logic [icache_pkg::DATA_W-1:0]   cpu_req_data
);
    import icache_pkg::*;

    logic [DATA_W-1:0]   mem [NUM_LINES][WORDS_PER_LINE];
    logic [INDEX_W-1:0]  line_idx;
    logic [OFFSET_W-1:0] rd_offset;

    assign line_idx  = cpu_req_addr[INDEX_LSB +: INDEX_W];
    assign rd_offset = cpu_req_addr[OFFSET_LSB +: OFFSET_W];

    // refill words go to the line of the pending request
    always_ff @(posedge clk)
    begin
        if (data_we)
        begin
            mem[line_idx][wr_offset] <= wr_data;
        end
    end

    // registered read of the requested word
    always_ff @(posedge clk)
    begin
        cpu_req_data <= mem[line_idx][rd_offset];
    end

endmodule

`default_nettype wire

// File: icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           refill_start,
    input  logic [icache_pkg::ADDR_W-1:0]   cpu_req_addr,
    input  logic                           mem_req_ready,
    input  logic [icache_pkg::DATA_W-1:0]   mem_req_data,
    output logic [icache_pkg::ADDR_W-1:0]   mem_req_addr,
    output logic                           mem_req_valid,
    output logic                           data_we,
    output logic [icache_pkg::OFFSET_W-1:0] wr_offset,
    output logic [icache_pkg::DATA_W-1:0]   wr_data,
    output logic                           refill_done
);
    import icache_pkg::*;

    logic [OFFSET_W-1:0]       word_cnt;
    logic [ADDR_W-1:INDEX_LSB] line_base;
    logic                      last_word;

    assign last_word = (word_cnt == OFFSET_W'(WORDS_PER_LINE - 1));

    // tag and index of the line being filled
    always_ff @(posedge clk)
    begin
        if (refill_start)
        begin
            line_base <= cpu_req_addr[ADDR_W-1:INDEX_LSB];
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem_req_valid && mem_req_ready)
        begin
            wr_data <= mem_req_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
            data_we       <= 1'b0;
            refill_done   <= 1'b0;
            word_cnt      <= '0;
        end
        else
        begin
            data_we     <= 1'b0;
            refill_done <= 1'b0;
            if (refill_start)
            begin
                word_cnt      <= '0;
                mem_req_valid <= 1'b1;
            end
            else if (mem_req_valid && mem_req_ready)
            begin
                mem_req_valid <= 1'b0;
                data_we       <= 1'b1;
            end
            else if (data_we)
            begin
                // after the word write request the next word or finish
                if (last_word)
                begin
                    refill_done <= 1'b1;
                end
                else
                begin
                    word_cnt      <= word_cnt + 1'b1;
                    mem_req_valid <= 1'b1;
                end
            end
        end
    end

    assign mem_req_addr = {line_base, word_cnt, {BYTE_OFF_W{1'b0}}};
    assign wr_offset    = word_cnt;

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [icache_pkg::ADDR_W-1:0] cpu_req_addr,
    input  logic                         cpu_req_valid,
    input  logic                         flush,
    output logic [icache_pkg::DATA_W-1:0] cpu_req_data,
    output logic                         cpu_req_ready,
    output logic [icache_pkg::ADDR_W-1:0] mem_req_addr,
    output logic                         mem_req_valid,
    input  logic [icache_pkg::DATA_W-1:0] mem_req_data,
    input  logic                         mem_req_ready
);
    import icache_pkg::*;

    logic                lookup_en;
    logic                refill_start;
    logic                tag_write;
    logic                flush_all;
    logic                hit;
    logic                refill_done;
    logic                data_we;
    logic [OFFSET_W-1:0] wr_offset;
    logic [DATA_W-1:0]   wr_data;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .flush         (flush),
        .hit           (hit),
        .refill_done   (refill_done),
        .lookup_en     (lookup_en),
        .refill_start  (refill_start),
        .tag_write     (tag_write),
        .flush_all     (flush_all),
        .cpu_req_ready (cpu_req_ready)
    );

    icache_tag_array u_tag_array (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .cpu_req_addr (cpu_req_addr),
        .tag_write    (tag_write),
        .flush_all    (flush_all),
        .hit          (hit)
    );

    icache_data_array u_data_array (
        .clk          (clk),
        .cpu_req_addr (cpu_req_addr),
        .data_we      (data_we),
        .wr_offset    (wr_offset),
        .wr_data      (wr_data),
        .cpu_req_data (cpu_req_data)
    );

    icache_refill u_refill (
        .clk           (clk),
        .rst           (rst),
        .refill_start  (refill_start),
        .cpu_req_addr  (cpu_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .data_we       (data_we),
        .wr_offset     (wr_offset),
        .wr_data       (wr_data),
        .refill_done   (refill_done)
    );

endmodule

`default_nettype wire

// File: icache_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module icache_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic                          cpu_req_ready,
    input logic                          mem_req_valid,
    input logic                          mem_req_ready,
    input logic [icache_pkg::ADDR_W-1:0] mem_req_addr,
    input icache_pkg::ctrl_state_t       state
);
    import icache_pkg::*;

    // request held with the same address until accepted
    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("memory request dropped or changed before mem_req_ready");

    cpu_ready_single: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |=> !cpu_req_ready)
        else $error("cpu_req_ready held for two cycles");

    // no memory traffic while idle
    idle_no_mem_req: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> !mem_req_valid)
        else $error("mem_req_valid high in IDLE");

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    // 8 ns period
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // held over the first 4 rising edges
    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
    input  logic        clk,
    input  logic [31:0] mem_req_addr,
    input  logic        mem_req_valid,
    output logic        mem_req_ready,
    output logic [31:0] mem_req_data
);
    integer      seed;
    int          delay;
    logic [31:0] addr;

    initial
    begin
        seed          = 32'h0c15_c40f;
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
        forever
        begin
            @(negedge clk);
            if (mem_req_valid)
            begin
                addr  = mem_req_addr;
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                // word contents follow from the address alone
                mem_req_ready = 1'b1;
                mem_req_data  = addr ^ 32'ha5a5_0000;
                @(posedge clk);
                #1;
                mem_req_ready = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] cpu_req_addr,
    input  logic        cpu_req_valid,
    input  logic        flush,
    input  logic [31:0] cpu_req_data,
    input  logic        cpu_req_ready,
    input  logic [31:0] mem_req_addr,
    input  logic        mem_req_valid,
    input  logic        mem_req_ready,
    output int          error_count,
    output int          check_count
);
    // reference lines indexed by addr[7:4] with tag addr[31:8]
    logic        ref_valid [16];
    logic [23:0] ref_tag [16];
    logic [31:0] mem_reads [$];

    initial
    begin
        error_count = 0;
        check_count = 0;
    end

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic check_response();
        logic [3:0]  idx;
        logic [31:0] line_base;
        int          exp_reads;
        idx       = cpu_req_addr[7:4];
        line_base = {cpu_req_addr[31:4], 4'h0};
        exp_reads = (ref_valid[idx] && ref_tag[idx] == cpu_req_addr[31:8]) ? 0 : 4;
        check_count++;
        if (cpu_req_data !== (cpu_req_addr ^ 32'ha5a5_0000))
            report_mismatch($sformatf("fetch %h returned %h, expected %h", cpu_req_addr,
                cpu_req_data, cpu_req_addr ^ 32'ha5a5_0000));
        if (mem_reads.size() != exp_reads)
        begin
            report_mismatch($sformatf("fetch %h took %0d memory reads, expected %0d",
                cpu_req_addr, mem_reads.size(), exp_reads));
        end
        else
        begin
            // refill walks the line in ascending word order
            for (int k = 0; k < exp_reads; k++)
            begin
                if (mem_reads[k] !== line_base + 32'(4 * k))
                    report_mismatch($sformatf("fetch %h read %0d went to %h, expected %h",
                        cpu_req_addr, k, mem_reads[k], line_base + 32'(4 * k)));
            end
        end
        mem_reads.delete();
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = cpu_req_addr[31:8];
    endtask

    always @(negedge clk)
    begin
        if (rst || (flush && !cpu_req_valid))
        begin
            for (int i = 0; i < 16; i++)
                ref_valid[i] = 1'b0;
        end
        if (rst)
            mem_reads.delete();
        else if (mem_req_valid && mem_req_ready)
            mem_reads.push_back(mem_req_addr);
        if (!rst && cpu_req_ready)
        begin
            if (!cpu_req_valid)
            begin
                report_mismatch("cache answered with no fetch pending");
            end
            else
            begin
                check_response();
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_icache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_icache;
    typedef enum logic {OP_FETCH, OP_FLUSH} op_t;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int DRIVE_DELAY    = 1;

    logic        clk;
    logic        rst;
    logic [31:0] cpu_req_addr;
    logic        cpu_req_valid;
    logic        flush;
    logic [31:0] cpu_req_data;
    logic        cpu_req_ready;
    logic [31:0] mem_req_addr;
    logic        mem_req_valid;
    logic [31:0] mem_req_data;
    logic        mem_req_ready;
    op_t         op_tab [$];
    logic [31:0] addr_tab [$];
    int          fetch_total;
    int          timeouts;
    int          error_count;
    int          check_count;

    tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    icache_top dut (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .flush         (flush),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    tb_mem_model u_mem_model (
        .clk           (clk),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

    tb_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .flush         (flush),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    bind icache_top icache_assertions u_assertions (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .state         (u_ctrl.state)
    );

    task automatic add_entry(input op_t op, input logic [31:0] addr);
        op_tab.push_back(op);
        addr_tab.push_back(addr);
    endtask

    task automatic wait_for_response(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            seen = cpu_req_ready;
            cycles++;
        end
    endtask

    initial
    begin
        logic seen;
        int   cycles;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        flush         = 1'b0;
        fetch_total   = 0;
        timeouts      = 0;
        // cold line and then every word of it again
        add_entry(OP_FETCH, 32'h0000_1004);
        add_entry(OP_FETCH, 32'h0000_1000);
        add_entry(OP_FETCH, 32'h0000_100c);
        add_entry(OP_FETCH, 32'h0000_1008);
        // index 0 with two tags
        add_entry(OP_FETCH, 32'h0002_1000);
        add_entry(OP_FETCH, 32'h0000_1004);
        add_entry(OP_FETCH, 32'h0002_1008);
        add_entry(OP_FETCH, 32'h0002_100c);
        // index 3 resident and then flushed
        add_entry(OP_FETCH, 32'h00ab_cd34);
        add_entry(OP_FLUSH, 32'h0000_0000);
        add_entry(OP_FETCH, 32'h00ab_cd30);
        add_entry(OP_FETCH, 32'h0002_1004);
        add_entry(OP_FETCH, 32'hffff_fffc);
        add_entry(OP_FETCH, 32'h1234_5678);
        add_entry(OP_FETCH, 32'hffff_fff0);
        add_entry(OP_FETCH, 32'h1234_5674);
        add_entry(OP_FETCH, 32'h8000_00a8);

        cycles = 0;
        while (rst && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rst)
        begin
            $display("reset was never released");
            timeouts++;
        end
        @(posedge clk);
        #DRIVE_DELAY;

        for (int i = 0; i < op_tab.size() && timeouts == 0; i++)
        begin
            if (op_tab[i] == OP_FLUSH)
            begin
                cpu_req_valid = 1'b0;
                flush         = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                flush = 1'b0;
            end
            else
            begin
                // valid stays high between fetches
                cpu_req_addr  = addr_tab[i];
                cpu_req_valid = 1'b1;
                fetch_total++;
                wait_for_response(seen);
                if (!seen)
                begin
                    $display("no response within %0d cycles to the fetch of %h",
                        TIMEOUT_CYCLES, addr_tab[i]);
                    timeouts++;
                end
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end

        cpu_req_valid = 1'b0;
        repeat (4) @(posedge clk);
        if (check_count != fetch_total)
            $display("only %0d of %0d fetches got a checked response", check_count, fetch_total);
        $display("fetches %0d, checked %0d, errors %0d, timeouts %0d",
            fetch_total, check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count == fetch_total)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: icache.f
icache_pkg.sv
icache_ctrl.sv
icache_tag_array.sv
icache_data_array.sv
icache_refill.sv
icache_top.sv
icache_assertions.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_checker.sv
tb_icache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the icache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        --top-module tb_icache -f icache.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_icache)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
